/* dv/tb_backend.sv */
`timescale 1ns/1ps

module tb_backend;

    localparam int NUM_INSTS = 2000;
    localparam int DRAIN_MAX = 50;

    typedef struct packed {
        logic        en;
        logic        ill;
        logic [4:0]  addr;
        logic [31:0] data;
    } wb_exp_t;

    // opcode fields of the supported words and some unused 3R slots
    localparam logic [16:0] OPC3 [7] = '{17'h20, 17'h22, 17'h24, 17'h25, 17'h29, 17'h2a, 17'h2b};
    localparam logic [9:0]  OPC2 [4] = '{10'h0a, 10'h0d, 10'h0e, 10'h0f};
    localparam logic [16:0] HOLES [4] = '{17'h21, 17'h23, 17'h26, 17'h2c};

    logic        clk;
    logic        rst_n;
    logic        inst_valid;
    logic [31:0] inst;
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic        illegal;

    logic [31:0] model_regs [32];
    wb_exp_t     exp_q [$];
    int          errors = 0;
    int          checks = 0;
    int          cycle = 0;
    int          first_cycle = 0;
    bit          started = 1'b0;

    backend DUT (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .inst_valid_i(inst_valid),
        .inst_i      (inst),
        .wb_en_o     (wb_en),
        .wb_addr_o   (wb_addr),
        .wb_data_o   (wb_data),
        .illegal_o   (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // mostly r0..r4 so that back-to-back hazards show up often
    function automatic logic [4:0] pick_reg();
        if ($urandom_range(3, 0) != 0) begin
            return 5'($urandom_range(4, 0));
        end
        return 5'($urandom_range(31, 0));
    endfunction

    // drive one word and run it through the reference model
    task automatic issue_one();
        int          sel;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [11:0] imm12;
        logic [19:0] imm20;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] bi;
        logic [31:0] res;
        wb_exp_t     e;
        sel   = int'($urandom_range(15, 0));
        rd    = pick_reg();
        rj    = pick_reg();
        rk    = pick_reg();
        imm12 = 12'($urandom);
        imm20 = 20'($urandom);
        a     = model_regs[rj];
        b     = model_regs[rk];
        bi    = (sel == 11) ? {{20{imm12[11]}}, imm12} : {20'b0, imm12};
        e     = '0;
        inst_valid = (sel >= 2);
        if (sel < 2) begin
            inst = $urandom;
        end else if (sel == 2) begin
            inst = {HOLES[$urandom_range(3, 0)], rk, rj, rd};
        end else if (sel == 3) begin
            inst = {6'h3f, 26'($urandom)};
        end else if (sel <= 10) begin
            inst = {OPC3[sel-4], rk, rj, rd};
        end else if (sel <= 14) begin
            inst = {OPC2[sel-11], imm12, rj, rd};
        end else begin
            inst = {7'h0a, imm20, rd};
        end
        case (sel)
            4:       res = a + b;
            5:       res = a - b;
            6:       res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            7:       res = (a < b) ? 32'd1 : 32'd0;
            8:       res = a & b;
            9:       res = a | b;
            10:      res = a ^ b;
            11:      res = a + bi;
            12:      res = a & bi;
            13:      res = a | bi;
            14:      res = a ^ bi;
            default: res = {imm20, 12'b0};
        endcase
        e.ill = (sel == 2 || sel == 3);
        // r0 stays zero, so no writeback either
        if (sel >= 4 && rd != 5'd0) begin
            model_regs[rd] = res;
            e.en   = 1'b1;
            e.addr = rd;
            e.data = res;
        end
        exp_q.push_back(e);
    endtask

    always @(negedge clk) begin
        wb_exp_t e;
        if (rst_n && !(started && cycle >= first_cycle + 3)) begin
            checks++;
            assert (!wb_en && !illegal) else begin
                $display("Mismatch at %0t: writeback active before first result", $time);
                errors++;
            end
        end else if (started && exp_q.size() != 0) begin
            e = exp_q.pop_front();
            checks++;
            assert (wb_en == e.en && illegal == e.ill) else begin
                $display("Mismatch at %0t: en/illegal %b/%b, expected %b/%b",
                         $time, wb_en, illegal, e.en, e.ill);
                errors++;
            end
            if (e.en) begin
                assert (wb_addr == e.addr && wb_data == e.data) else begin
                    $display("Mismatch at %0t: r%0d = %h, expected r%0d = %h",
                             $time, wb_addr, wb_data, e.addr, e.data);
                    errors++;
                end
            end
        end
    end

    initial begin
        int wait_cnt;
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        void'($urandom(32'h4264));
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < NUM_INSTS; i++) begin
            @(posedge clk);
            #1;
            if (!started) begin
                first_cycle = cycle;
                started     = 1'b1;
            end
            issue_one();
        end
        @(posedge clk);
        #1;
        inst_valid = 1'b0;
        inst       = '0;
        wait_cnt   = 0;
        while (exp_q.size() != 0 && wait_cnt < DRAIN_MAX) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout: %0d expected writebacks never arrived", exp_q.size());
            errors++;
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* flist.f */
src/pipeline_types.sv
src/dispatch_regfile_if.sv
src/id.sv
src/dispatch.sv
src/regfile.sv
src/ex.sv
src/backend.sv
dv/tb_backend.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_backend -f flist.f -o Vtb_backend

./obj_dir/Vtb_backend | tee sim.log

if grep -qx "Testbench passed" sim.log; then
    exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

/* src/backend.sv */
`timescale 1ns/1ps

module backend
    import pipeline_types::*;
(
    input  logic                  clk,
    input  logic                  rst_n_i,

    // from front end
    input  logic                  inst_valid_i,
    input  logic [31:0]           inst_i,

    // writeback
    output logic                  wb_en_o,
    output logic [REG_ADDR_W-1:0] wb_addr_o,
    output logic [XLEN-1:0]       wb_data_o,
    output logic                  illegal_o
);

    dispatch_regfile_if dispatch_regfile_io();

    id_dispatch_t  id_o;
    dispatch_ex_t  dispatch_o;
    push_forward_t ex_push_forward;
    push_forward_t wb_push_forward;

    id u_id (
        .clk,
        .rst_n_i,

        .inst_valid_i(inst_valid_i),
        .inst_i(inst_i),

        .id_o(id_o)
    );

    dispatch u_dispatch (
        .clk,
        .rst_n_i,

        .id_i(id_o),
        .rf(dispatch_regfile_io.master),

        .ex_push_forward_i(ex_push_forward),
        .wb_push_forward_i(wb_push_forward),

        .dispatch_o(dispatch_o)
    );

    regfile u_regfile (
        .clk,
        .rst_n_i,

        .wr_i(wb_push_forward),
        .rf(dispatch_regfile_io.slave)
    );

    ex u_ex (
        .clk,
        .rst_n_i,

        .ex_i(dispatch_o),

        .ex_push_forward_o(ex_push_forward),
        .wb_o(wb_push_forward),
        .illegal_o(illegal_o)
    );

    // wb register feeds both the file and the outputs
    assign wb_en_o   = wb_push_forward.reg_write_en;
    assign wb_addr_o = wb_push_forward.reg_write_addr;
    assign wb_data_o = wb_push_forward.reg_write_data;

endmodule

/* src/dispatch.sv */
`timescale 1ns/1ps

module dispatch
    import pipeline_types::*;
(
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  id_dispatch_t              id_i,
    dispatch_regfile_if.master        rf,
    input  push_forward_t             ex_push_forward_i,
    input  push_forward_t             wb_push_forward_i,
    output dispatch_ex_t              dispatch_o
);

    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic [XLEN-1:0] imm_ext;
    dispatch_ex_t    dispatch_d;

    // newest pending write wins, ex is younger than wb
    function automatic logic [XLEN-1:0] fwd_operand(
        input logic [REG_ADDR_W-1:0] src,
        input logic [XLEN-1:0]       rf_data,
        input push_forward_t         ex_pf,
        input push_forward_t         wb_pf
    );
        logic [XLEN-1:0] val;
        val = rf_data;
        if (src != '0 && wb_pf.reg_write_en && wb_pf.reg_write_addr == src) begin
            val = wb_pf.reg_write_data;
        end
        if (src != '0 && ex_pf.reg_write_en && ex_pf.reg_write_addr == src) begin
            val = ex_pf.reg_write_data;
        end
        return val;
    endfunction

    assign rf.raddr1 = id_i.rj;
    assign rf.raddr2 = id_i.rk;

    assign src1 = fwd_operand(id_i.rj, rf.rdata1, ex_push_forward_i, wb_push_forward_i);
    assign src2 = fwd_operand(id_i.rk, rf.rdata2, ex_push_forward_i, wb_push_forward_i);

    always_comb begin
        case (id_i.imm_kind)
            IMM_SEXT12:  imm_ext = {{(XLEN-12){id_i.imm[11]}}, id_i.imm[11:0]};
            IMM_ZEXT12:  imm_ext = {{(XLEN-12){1'b0}}, id_i.imm[11:0]};
            IMM_UPPER20: imm_ext = {id_i.imm[19:0], 12'b0};
            default:     imm_ext = '0;
        endcase
    end

    always_comb begin
        dispatch_d.valid        = id_i.valid;
        dispatch_d.illegal      = id_i.illegal;
        dispatch_d.aluop        = id_i.aluop;
        dispatch_d.a            = src1;
        dispatch_d.b            = (id_i.imm_kind == IMM_NONE) ? src2 : imm_ext;
        dispatch_d.rd           = id_i.rd;
        dispatch_d.reg_write_en = id_i.reg_write_en;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dispatch_o <= '0;
        end else begin
            dispatch_o <= dispatch_d;
        end
    end

endmodule

/* src/dispatch_regfile_if.sv */
`timescale 1ns/1ps

interface dispatch_regfile_if
    import pipeline_types::*;
();

    logic [REG_ADDR_W-1:0] raddr1;
    logic [REG_ADDR_W-1:0] raddr2;
    logic [XLEN-1:0]       rdata1;
    logic [XLEN-1:0]       rdata2;

    // dispatch side
    modport master (output raddr1, output raddr2, input rdata1, input rdata2);

    // register file side
    modport slave (input raddr1, input raddr2, output rdata1, output rdata2);

endinterface

/* src/ex.sv */
`timescale 1ns/1ps

module ex
    import pipeline_types::*;
(
    input  logic          clk,
    input  logic          rst_n_i,
    input  dispatch_ex_t  ex_i,
    output push_forward_t ex_push_forward_o,
    output push_forward_t wb_o,
    output logic          illegal_o
);

    logic [XLEN-1:0]       result;
    logic                  wb_en_q;
    logic [REG_ADDR_W-1:0] wb_addr_q;
    logic [XLEN-1:0]       wb_data_q;

    always_comb begin
        case (ex_i.aluop)
            ALU_ADD:  result = ex_i.a + ex_i.b;
            ALU_SUB:  result = ex_i.a - ex_i.b;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(ex_i.a) < $signed(ex_i.b)};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, ex_i.a < ex_i.b};
            ALU_AND:  result = ex_i.a & ex_i.b;
            ALU_OR:   result = ex_i.a | ex_i.b;
            ALU_XOR:  result = ex_i.a ^ ex_i.b;
            ALU_LUI:  result = ex_i.b;
            default:  result = '0;
        endcase
    end

    // bubbles must never look like a pending write
    always_comb begin
        ex_push_forward_o.reg_write_en   = ex_i.valid & ex_i.reg_write_en;
        ex_push_forward_o.reg_write_addr = ex_i.rd;
        ex_push_forward_o.reg_write_data = result;
    end

    // writeback stage
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_en_q   <= 1'b0;
            illegal_o <= 1'b0;
        end else begin
            wb_en_q   <= ex_push_forward_o.reg_write_en;
            illegal_o <= ex_i.valid & ex_i.illegal;
        end
    end

    always_ff @(posedge clk) begin
        wb_addr_q <= ex_push_forward_o.reg_write_addr;
        wb_data_q <= ex_push_forward_o.reg_write_data;
    end

    assign wb_o.reg_write_en   = wb_en_q;
    assign wb_o.reg_write_addr = wb_addr_q;
    assign wb_o.reg_write_data = wb_data_q;

endmodule

/* src/id.sv */
`timescale 1ns/1ps

module id
    import pipeline_types::*;
(
    input  logic         clk,
    input  logic         rst_n_i,
    input  logic         inst_valid_i,
    input  logic [31:0]  inst_i,
    output id_dispatch_t id_o
);

    logic [OPC_3R_W-1:0]    opc_3r;
    logic [OPC_2RI12_W-1:0] opc_2ri12;
    logic [OPC_1RI20_W-1:0] opc_1ri20;

    logic      match_3r;
    logic      match_2ri12;
    logic      match_lu12i;
    logic      legal;
    alu_op_e   aluop_3r;
    alu_op_e   aluop_2ri12;
    imm_kind_e kind_2ri12;

    id_dispatch_t id_d;

    assign opc_3r    = inst_i[31:15];
    assign opc_2ri12 = inst_i[31:22];
    assign opc_1ri20 = inst_i[31:25];

    always_comb begin
        match_3r = 1'b1;
        aluop_3r = ALU_ADD;
        case (opc_3r)
            OPC_ADD_W: aluop_3r = ALU_ADD;
            OPC_SUB_W: aluop_3r = ALU_SUB;
            OPC_SLT:   aluop_3r = ALU_SLT;
            OPC_SLTU:  aluop_3r = ALU_SLTU;
            OPC_AND:   aluop_3r = ALU_AND;
            OPC_OR:    aluop_3r = ALU_OR;
            OPC_XOR:   aluop_3r = ALU_XOR;
            default:   match_3r = 1'b0;
        endcase
    end

    // addi.w sign-extends, the logic forms zero-extend
    always_comb begin
        match_2ri12 = 1'b1;
        aluop_2ri12 = ALU_ADD;
        kind_2ri12  = IMM_ZEXT12;
        case (opc_2ri12)
            OPC_ADDI_W: begin
                aluop_2ri12 = ALU_ADD;
                kind_2ri12  = IMM_SEXT12;
            end
            OPC_ANDI: aluop_2ri12 = ALU_AND;
            OPC_ORI:  aluop_2ri12 = ALU_OR;
            OPC_XORI: aluop_2ri12 = ALU_XOR;
            default:  match_2ri12 = 1'b0;
        endcase
    end

    assign match_lu12i = (opc_1ri20 == OPC_LU12I_W);
    assign legal       = match_3r | match_2ri12 | match_lu12i;

    always_comb begin
        id_d          = '0;
        id_d.aluop    = ALU_ADD;
        id_d.imm_kind = IMM_NONE;
        if (inst_valid_i) begin
            id_d.valid = 1'b1;
            id_d.rd    = inst_i[4:0];
            if (match_3r) begin
                id_d.aluop = aluop_3r;
                id_d.rj    = inst_i[9:5];
                id_d.rk    = inst_i[14:10];
            end else if (match_2ri12) begin
                id_d.aluop    = aluop_2ri12;
                id_d.imm_kind = kind_2ri12;
                id_d.imm      = {{(XLEN-12){1'b0}}, inst_i[21:10]};
                id_d.rj       = inst_i[9:5];
            end else if (match_lu12i) begin
                id_d.aluop    = ALU_LUI;
                id_d.imm_kind = IMM_UPPER20;
                id_d.imm      = {{(XLEN-20){1'b0}}, inst_i[24:5]};
            end
            id_d.illegal      = ~legal;
            // r0 is hardwired, drop the write
            id_d.reg_write_en = legal && (inst_i[4:0] != '0);
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_o <= '0;
        end else begin
            id_o <= id_d;
        end
    end

endmodule

/* src/pipeline_types.sv */
package pipeline_types;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int OPC_3R_W    = 17;
    localparam int OPC_2RI12_W = 10;
    localparam int OPC_1RI20_W = 7;

    // 3R major opcodes, inst[31:15]
    localparam logic [OPC_3R_W-1:0] OPC_ADD_W = 17'h00020;
    localparam logic [OPC_3R_W-1:0] OPC_SUB_W = 17'h00022;
    localparam logic [OPC_3R_W-1:0] OPC_SLT   = 17'h00024;
    localparam logic [OPC_3R_W-1:0] OPC_SLTU  = 17'h00025;
    localparam logic [OPC_3R_W-1:0] OPC_AND   = 17'h00029;
    localparam logic [OPC_3R_W-1:0] OPC_OR    = 17'h0002a;
    localparam logic [OPC_3R_W-1:0] OPC_XOR   = 17'h0002b;

    // 2RI12 opcodes, inst[31:22]
    localparam logic [OPC_2RI12_W-1:0] OPC_ADDI_W = 10'h00a;
    localparam logic [OPC_2RI12_W-1:0] OPC_ANDI   = 10'h00d;
    localparam logic [OPC_2RI12_W-1:0] OPC_ORI    = 10'h00e;
    localparam logic [OPC_2RI12_W-1:0] OPC_XORI   = 10'h00f;

    // 1RI20 opcode, inst[31:25]
    localparam logic [OPC_1RI20_W-1:0] OPC_LU12I_W = 7'h0a;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        IMM_NONE,
        IMM_SEXT12,
        IMM_ZEXT12,
        IMM_UPPER20
    } imm_kind_e;

    typedef struct packed {
        logic                  valid;
        logic                  illegal;
        alu_op_e               aluop;
        imm_kind_e             imm_kind;
        // raw immediate field, right aligned
        logic [XLEN-1:0]       imm;
        logic [REG_ADDR_W-1:0] rj;
        logic [REG_ADDR_W-1:0] rk;
        logic [REG_ADDR_W-1:0] rd;
        logic                  reg_write_en;
    } id_dispatch_t;

    typedef struct packed {
        logic                  valid;
        logic                  illegal;
        alu_op_e               aluop;
        logic [XLEN-1:0]       a;
        logic [XLEN-1:0]       b;
        logic [REG_ADDR_W-1:0] rd;
        logic                  reg_write_en;
    } dispatch_ex_t;

    typedef struct packed {
        logic                  reg_write_en;
        logic [REG_ADDR_W-1:0] reg_write_addr;
        logic [XLEN-1:0]       reg_write_data;
    } push_forward_t;

endpackage

/* src/regfile.sv */
`timescale 1ns/1ps

module regfile
    import pipeline_types::*;
(
    input  logic               clk,
    input  logic               rst_n_i,
    input  push_forward_t      wr_i,
    dispatch_regfile_if.slave  rf
);

    localparam int NUM_REGS = 1 << REG_ADDR_W;

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.reg_write_en && wr_i.reg_write_addr != '0) begin
            regs[wr_i.reg_write_addr] <= wr_i.reg_write_data;
        end
    end

    // no bypass here, dispatch forwards wb itself
    assign rf.rdata1 = (rf.raddr1 == '0) ? '0 : regs[rf.raddr1];
    assign rf.rdata2 = (rf.raddr2 == '0) ? '0 : regs[rf.raddr2];

endmodule
